/* compile.f */
+incdir+.
cplx_exec_pkg.sv
complex_alu.sv
issue_router.sv
writeback_arbiter.sv
complex_exec_top.sv
tb_complex_exec.sv

/* complex_alu.sv */
`timescale 1ns/1ps

module complex_alu #(
  parameter int data_w_p = cplx_exec_pkg::DATA_W,
  parameter int tag_w_p  = cplx_exec_pkg::TAG_W
) (
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     start_i,      // one cycle, from router
  input  cplx_exec_pkg::issue_pkt_t issue_pkt_i, // shared across lanes
  input  logic                     grant_i,      // arbiter took our result
  output logic                     busy_o,
  output logic                     done_o,
  output cplx_exec_pkg::wb_pkt_t   wb_pkt_o
);

  // enough bits to count the longest latency
  localparam int cnt_w_lp = $clog2(cplx_exec_pkg::DIV_LAT + 1);

  logic                  busy_r;              // lane owned by an instruction
  logic                  run_r;               // latency still counting
  logic                  done_r;              // result waiting for grant
  logic [cnt_w_lp-1:0]   lat_cnt_r;           // cycles left until done
  logic [cnt_w_lp-1:0]   start_lat;           // latency of the incoming op

  cplx_exec_pkg::alu_op_e op_r;               // latched opcode
  logic [tag_w_p-1:0]    tag_r;               // latched tag
  logic [data_w_p-1:0]   src1_r;              // latched operands
  logic [data_w_p-1:0]   src2_r;

  logic signed [data_w_p-1:0]   src1_s;
  logic signed [data_w_p-1:0]   div_b_s;      // divisor, never zero
  logic [data_w_p-1:0]          div_b_u;
  logic signed [2*data_w_p-1:0] prod_s;       // full signed product
  logic [2*data_w_p-1:0]        prod_u;       // full unsigned product
  logic signed [data_w_p-1:0]   quo_s;
  logic signed [data_w_p-1:0]   rem_s;
  logic [data_w_p-1:0]          quo_u;
  logic [data_w_p-1:0]          rem_u;
  logic                         div_zero;     // src2 == 0
  logic                         div_ovf;      // most negative / -1

  logic [data_w_p-1:0]          result_c;
  cplx_exec_pkg::exec_flags_t   flags_c;

  // latency per opcode, sampled at start
  always_comb begin
    case (issue_pkt_i.op)
      cplx_exec_pkg::mult_l,
      cplx_exec_pkg::mult_h,
      cplx_exec_pkg::multu_l,
      cplx_exec_pkg::multu_h: start_lat = cnt_w_lp'(cplx_exec_pkg::MUL_LAT);
      cplx_exec_pkg::syscall: start_lat = cnt_w_lp'(cplx_exec_pkg::SYS_LAT);
      default:                start_lat = cnt_w_lp'(cplx_exec_pkg::DIV_LAT);
    endcase
  end

  // lane control, start -> count -> done -> drained
  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_r    <= 1'b0;
      run_r     <= 1'b0;
      done_r    <= 1'b0;
      lat_cnt_r <= '0;
    end else if (start_i) begin
      busy_r <= 1'b1;                          // visible the cycle after start
      if (start_lat == cnt_w_lp'(1)) begin
        done_r <= 1'b1;                        // single cycle op
        run_r  <= 1'b0;
      end else begin
        run_r     <= 1'b1;
        lat_cnt_r <= start_lat - cnt_w_lp'(1);
      end
    end else if (run_r) begin
      lat_cnt_r <= lat_cnt_r - cnt_w_lp'(1);
      if (lat_cnt_r == cnt_w_lp'(1)) begin
        run_r  <= 1'b0;
        done_r <= 1'b1;                        // result ready at start + lat
      end
    end else if (grant_i) begin
      done_r <= 1'b0;                          // drained
      busy_r <= 1'b0;                          // free again next cycle
    end
  end

  // operand capture, held until the next start
  always_ff @(posedge clk) begin
    if (start_i) begin
      op_r   <= issue_pkt_i.op;
      tag_r  <= issue_pkt_i.tag;
      src1_r <= issue_pkt_i.src1;
      src2_r <= issue_pkt_i.src2;
    end
  end

  assign src1_s   = $signed(src1_r);
  assign div_zero = (src2_r == '0);
  assign div_ovf  = (src1_r == {1'b1, {(data_w_p-1){1'b0}}}) && (src2_r == '1);

  // substitute a divisor of one so the dividers never see zero
  assign div_b_u = div_zero ? data_w_p'(1) : src2_r;
  assign div_b_s = $signed(div_b_u);

  // double width products, operands extended explicitly
  assign prod_s = $signed({{data_w_p{src1_r[data_w_p-1]}}, src1_r}) *
                  $signed({{data_w_p{src2_r[data_w_p-1]}}, src2_r});
  assign prod_u = {{data_w_p{1'b0}}, src1_r} * {{data_w_p{1'b0}}, src2_r};

  assign quo_s = src1_s / div_b_s;            // truncates toward zero
  assign rem_s = src1_s % div_b_s;            // sign follows dividend
  assign quo_u = src1_r / div_b_u;
  assign rem_u = src1_r % div_b_u;

  // result select plus corner-case overrides
  always_comb begin
    result_c = '0;
    flags_c  = '0;
    case (op_r)
      cplx_exec_pkg::mult_l:  result_c = prod_s[data_w_p-1:0];
      cplx_exec_pkg::mult_h:  result_c = prod_s[2*data_w_p-1:data_w_p];
      cplx_exec_pkg::multu_l: result_c = prod_u[data_w_p-1:0];
      cplx_exec_pkg::multu_h: result_c = prod_u[2*data_w_p-1:data_w_p];
      cplx_exec_pkg::div_l: begin
        if (div_zero)     result_c = '1;     // all ones quotient
        else if (div_ovf) result_c = src1_r; // most negative back
        else              result_c = quo_s;
      end
      cplx_exec_pkg::div_h: begin
        if (div_zero)     result_c = src1_r; // remainder is dividend
        else if (div_ovf) result_c = '0;
        else              result_c = rem_s;
      end
      cplx_exec_pkg::divu_l:  result_c = div_zero ? '1 : quo_u;
      cplx_exec_pkg::divu_h:  result_c = div_zero ? src1_r : rem_u;
      default:                result_c = '0;  // syscall
    endcase
    if (op_r == cplx_exec_pkg::syscall) begin
      flags_c.exception = 1'b1;
    end else begin
      flags_c.executed = 1'b1;
      // only the four divide codes report a zero divisor
      flags_c.div_zero = div_zero && (op_r inside {cplx_exec_pkg::div_l, cplx_exec_pkg::div_h,
                                                   cplx_exec_pkg::divu_l, cplx_exec_pkg::divu_h});
    end
  end

  always_comb begin
    wb_pkt_o.tag    = tag_r;
    wb_pkt_o.result = result_c;
    wb_pkt_o.flags  = flags_c;
  end

  assign busy_o = busy_r;
  assign done_o = done_r;

  // router must never hand us a second op
  a_no_start_busy: assert property (@(posedge clk) disable iff (reset_i) start_i |-> !busy_r);
  // arbiter only grants a finished lane
  a_grant_done: assert property (@(posedge clk) disable iff (reset_i) grant_i |-> done_r);

endmodule

/* complex_exec_top.sv */
`timescale 1ns/1ps

module complex_exec_top #(
  parameter int num_lanes_p = 3,
  parameter int data_w_p    = cplx_exec_pkg::DATA_W,
  parameter int tag_w_p     = cplx_exec_pkg::TAG_W
) (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      issue_valid_i,
  input  cplx_exec_pkg::issue_pkt_t issue_pkt_i,
  output logic                      issue_ready_o,
  output logic                      wb_valid_o,
  output cplx_exec_pkg::wb_pkt_t    wb_pkt_o
);

  logic [num_lanes_p-1:0]                   lane_start;  // router -> lanes
  logic [num_lanes_p-1:0]                   lane_busy;   // lanes -> router
  logic [num_lanes_p-1:0]                   lane_done;   // lanes -> arbiter
  logic [num_lanes_p-1:0]                   lane_grant;  // arbiter -> lanes
  cplx_exec_pkg::issue_pkt_t                lane_pkt;    // shared issue bus
  cplx_exec_pkg::wb_pkt_t [num_lanes_p-1:0] lane_wb;     // per lane result

  issue_router #(
    .num_lanes_p (num_lanes_p)
  ) issue_router_inst (
    .clk           (clk),
    .reset_i       (reset_i),
    .issue_valid_i (issue_valid_i),
    .issue_pkt_i   (issue_pkt_i),
    .lane_busy_i   (lane_busy),
    .issue_ready_o (issue_ready_o),
    .start_o       (lane_start),
    .lane_pkt_o    (lane_pkt)
  );

  for (genvar k = 0; k < num_lanes_p; k++) begin : lane_g
    complex_alu #(
      .data_w_p (data_w_p),
      .tag_w_p  (tag_w_p)
    ) complex_alu_inst (
      .clk         (clk),
      .reset_i     (reset_i),
      .start_i     (lane_start[k]),
      .issue_pkt_i (lane_pkt),
      .grant_i     (lane_grant[k]),
      .busy_o      (lane_busy[k]),
      .done_o      (lane_done[k]),
      .wb_pkt_o    (lane_wb[k])
    );
  end

  writeback_arbiter #(
    .num_lanes_p (num_lanes_p)
  ) writeback_arbiter_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .done_i     (lane_done),
    .lane_wb_i  (lane_wb),
    .grant_o    (lane_grant),
    .wb_valid_o (wb_valid_o),
    .wb_pkt_o   (wb_pkt_o)
  );

  // packet fields are sized by the package, lanes by parameters
  a_width_match: assert property (@(posedge clk)
    (data_w_p == cplx_exec_pkg::DATA_W) && (tag_w_p == cplx_exec_pkg::TAG_W));

endmodule

/* cplx_exec_pkg.sv */
package cplx_exec_pkg;

  // datapath defaults, top level overrides data width
  parameter int DATA_W = 32;     // operand width
  parameter int TAG_W  = 6;      // rob tag width

  // start to done, in cycles
  parameter int MUL_LAT = 2;     // multiply lanes
  parameter int DIV_LAT = 4;     // divide, longest op
  parameter int SYS_LAT = 1;     // syscall only raises the flag

  // complex alu opcodes, _h divide codes return the remainder
  typedef enum logic [3:0] {
    mult_l  = 4'h0,              // signed product, low half
    mult_h  = 4'h1,              // signed product, high half
    multu_l = 4'h2,              // unsigned product, low half
    multu_h = 4'h3,              // unsigned product, high half
    div_l   = 4'h4,              // signed quotient
    div_h   = 4'h5,              // signed remainder
    divu_l  = 4'h6,              // unsigned quotient
    divu_h  = 4'h7,              // unsigned remainder
    syscall = 4'h8               // trap to the os
  } alu_op_e;

  // execution flags returned with every result
  typedef struct packed {
    logic executed;              // arithmetic op completed
    logic exception;             // syscall seen
    logic div_zero;              // divisor was zero
  } exec_flags_t;

  // one instruction from the issue queue
  typedef struct packed {
    logic [TAG_W-1:0]  tag;      // rob slot
    alu_op_e           op;       // what to do
    logic [DATA_W-1:0] src1;     // dividend / multiplicand
    logic [DATA_W-1:0] src2;     // divisor / multiplier
  } issue_pkt_t;

  // one result toward the register file
  typedef struct packed {
    logic [TAG_W-1:0]  tag;      // same tag as issued
    logic [DATA_W-1:0] result;   // selected half / quotient / remainder
    exec_flags_t       flags;    // status bits
  } wb_pkt_t;

endpackage

/* issue_router.sv */
`timescale 1ns/1ps

module issue_router #(
  parameter int num_lanes_p = 3
) (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      issue_valid_i,   // strobe from issue queue
  input  cplx_exec_pkg::issue_pkt_t issue_pkt_i,
  input  logic [num_lanes_p-1:0]    lane_busy_i,     // one per lane
  output logic                      issue_ready_o,   // some lane is free
  output logic [num_lanes_p-1:0]    start_o,         // one-hot lane start
  output cplx_exec_pkg::issue_pkt_t lane_pkt_o       // shared by all lanes
);

  logic [num_lanes_p-1:0]    claimed_r;    // picked last edge, busy not up yet
  logic [num_lanes_p-1:0]    free;         // neither busy nor claimed
  logic [num_lanes_p-1:0]    pick_oh;      // lowest free lane
  logic                      accept;       // strobe taken this edge
  cplx_exec_pkg::issue_pkt_t lane_pkt_r;

  assign free          = ~(lane_busy_i | claimed_r);
  assign issue_ready_o = |free;
  assign accept        = issue_valid_i && issue_ready_o;

  // priority pick, lane 0 wins
  always_comb begin : lowest_free
    logic found;
    found   = 1'b0;
    pick_oh = '0;
    for (int i = 0; i < num_lanes_p; i++) begin
      if (!found && free[i]) begin
        pick_oh[i] = 1'b1;
        found      = 1'b1;
      end
    end
  end

  // claim is one cycle long, busy covers the lane after that
  always_ff @(posedge clk) begin
    if (reset_i) begin
      claimed_r <= '0;
    end else begin
      claimed_r <= accept ? pick_oh : '0;
    end
  end

  // packet register, valid alongside start
  always_ff @(posedge clk) begin
    if (accept) begin
      lane_pkt_r <= issue_pkt_i;
    end
  end

  assign start_o    = claimed_r;     // start pulse is the claim itself
  assign lane_pkt_o = lane_pkt_r;

  // at most one lane started per cycle
  a_start_onehot: assert property (@(posedge clk) disable iff (reset_i) $onehot0(start_o));
  // issue queue must respect ready
  a_no_strobe_full: assert property (@(posedge clk) disable iff (reset_i)
                                     issue_valid_i |-> issue_ready_o);

endmodule

/* run.sh */
#!/bin/sh
# build and run the complex exec cluster testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_complex_exec -o Vtb_complex_exec

status=0
./obj_dir/Vtb_complex_exec > sim.log 2>&1 || status=$?
cat sim.log

# a crash or the fail message in the log both count as failure
if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
  echo "simulation FAILED, see sim.log"
  exit 1
fi
echo "simulation passed"

/* tb_complex_exec_tests.svh */
// idle cluster, nothing issued
task automatic reset_state_check();
  start_test("reset_state");
  @(negedge clk);
  assert (issue_ready_o === 1'b1) else begin
    $display("** Error %s: issue_ready_o expected 1 actual %b", cur_test, issue_ready_o);
    errors++;
  end
  assert (wb_valid_o === 1'b0) else begin
    $display("** Error %s: wb_valid_o expected 0 actual %b", cur_test, wb_valid_o);
    errors++;
  end
  repeat (idle_cycles_lp) begin
    @(negedge clk);
    assert (wb_valid_o === 1'b0) else begin
      $display("error in %s: writeback appeared with nothing issued", cur_test);
      errors++;
    end
  end
  finish_test();
endtask

task automatic multiply_ops();
  logic [data_w_lp-1:0] min_v;
  logic [data_w_lp-1:0] a;
  logic [data_w_lp-1:0] b;
  min_v = {1'b1, {(data_w_lp-1){1'b0}}};
  start_test("multiply");
  issue_group(cplx_exec_pkg::mult_l, min_v, min_v);   // only the high half set
  issue_group(cplx_exec_pkg::mult_l, ~min_v, ~min_v);
  issue_group(cplx_exec_pkg::mult_l, min_v, '1);      // -min does not fit
  issue_group(cplx_exec_pkg::mult_l, '1, '1);         // 1 signed, huge unsigned
  issue_group(cplx_exec_pkg::mult_l, ~min_v, min_v);
  issue_group(cplx_exec_pkg::mult_l, '0, '1);
  repeat (4) begin
    a = rand_word();
    b = rand_word();
    issue_group(cplx_exec_pkg::mult_l, a, b);
  end
  wait_drain();
  finish_test();
endtask

task automatic divide_ops();
  logic [data_w_lp-1:0] a;
  logic [data_w_lp-1:0] b;
  int                   sh;
  start_test("divide");
  repeat (4) begin
    a  = rand_word();
    b  = rand_word();
    sh = int'(rand_word() % 24);
    issue_group(cplx_exec_pkg::div_l, a, b >> sh);    // spread of quotient sizes
  end
  // truncation toward zero with mixed signs
  issue_group(cplx_exec_pkg::div_l, data_w_lp'(-7), data_w_lp'(2));
  issue_group(cplx_exec_pkg::div_l, data_w_lp'(7), data_w_lp'(-2));
  issue_group(cplx_exec_pkg::div_l, data_w_lp'(-7), data_w_lp'(-2));
  wait_drain();
  finish_test();
endtask

task automatic divide_corners();
  logic [data_w_lp-1:0] min_v;
  logic [data_w_lp-1:0] a;
  min_v = {1'b1, {(data_w_lp-1){1'b0}}};
  a     = rand_word();
  start_test("div_corners");
  issue_group(cplx_exec_pkg::div_l, a, '0);           // divide by zero
  issue_group(cplx_exec_pkg::div_l, min_v, '0);
  issue_group(cplx_exec_pkg::div_l, min_v, '1);       // signed overflow
  wait_drain();
  finish_test();
endtask

task automatic syscall_ops();
  logic [data_w_lp-1:0] a;
  logic [data_w_lp-1:0] b;
  start_test("syscall");
  repeat (3) begin
    a = rand_word();
    b = rand_word();
    issue_op(cplx_exec_pkg::syscall, a, b);           // operands ignored
  end
  wait_drain();
  finish_test();
endtask

// mixed ops as fast as ready allows, results may come back out of order
task automatic saturation_burst();
  logic [data_w_lp-1:0] a;
  logic [data_w_lp-1:0] b;
  int                   op_n;
  start_test("burst");
  saw_ready_low = 1'b0;
  for (int i = 0; i < burst_ops_lp; i++) begin
    if (i < lanes_lp) op_n = 4 + int'(rand_word() % 4);  // divides first, fills lanes
    else op_n = int'(rand_word() % 9);
    a = rand_word();
    b = rand_word();
    issue_op(cplx_exec_pkg::alu_op_e'(4'(op_n)), a, b);
  end
  wait_drain();
  assert (saw_ready_low) else begin
    $display("error in %s: issue_ready_o never dropped with all lanes busy", cur_test);
    errors++;
  end
  finish_test();
endtask

/* tb_complex_exec.sv */
`timescale 1ns/1ps

module tb_complex_exec;

  localparam int lanes_lp        = 3;
  localparam int data_w_lp       = cplx_exec_pkg::DATA_W;
  localparam int tag_w_lp        = cplx_exec_pkg::TAG_W;
  localparam int reset_cycles_lp = 8;
  localparam int idle_cycles_lp  = 16;     // quiet window after reset
  localparam int burst_ops_lp    = 24;     // well above the lane count
  // 10 multiply, 7 divide and 3 corner groups of four plus syscalls and burst
  localparam int total_ops_lp    = 4 * (10 + 7 + 3) + 3 + burst_ops_lp;
  localparam int watchdog_lp     = reset_cycles_lp + idle_cycles_lp +
                                   total_ops_lp * (cplx_exec_pkg::DIV_LAT + lanes_lp + 4);

  logic                      clk;
  logic                      reset_i;
  logic                      issue_valid_i;
  cplx_exec_pkg::issue_pkt_t issue_pkt_i;
  logic                      issue_ready_o;
  logic                      wb_valid_o;
  cplx_exec_pkg::wb_pkt_t    wb_pkt_o;

  cplx_exec_pkg::wb_pkt_t expected [2**tag_w_lp];  // scoreboard by tag
  logic                   pending  [2**tag_w_lp];  // tag in flight
  int                     outstanding = 0;
  logic [tag_w_lp-1:0]    next_tag = '0;
  logic [31:0]            rng_state = 32'd5;       // xorshift seed
  string                  cur_test = "none";
  int                     errors = 0;
  int                     checked = 0;
  int                     test_err0 = 0;           // counts at test start
  int                     test_chk0 = 0;
  int                     tests_pass = 0;
  int                     tests_fail = 0;
  logic                   saw_ready_low = 1'b0;    // all lanes taken at some point

  complex_exec_top #(
    .num_lanes_p (lanes_lp),
    .data_w_p    (data_w_lp),
    .tag_w_p     (tag_w_lp)
  ) complex_exec_top_inst (
    .clk           (clk),
    .reset_i       (reset_i),
    .issue_valid_i (issue_valid_i),
    .issue_pkt_i   (issue_pkt_i),
    .issue_ready_o (issue_ready_o),
    .wb_valid_o    (wb_valid_o),
    .wb_pkt_o      (wb_pkt_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                        // 40 ns period
  end

  initial begin
    repeat (watchdog_lp) @(posedge clk);
    $display("watchdog: run timed out after %0d cycles, %0d results never came back",
             watchdog_lp, outstanding);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [data_w_lp-1:0] rand_word();
    rng_state = xorshift32(rng_state);
    return data_w_lp'(rng_state);
  endfunction

  // double width product of two unsigned words by shift and add
  function automatic logic [2*data_w_lp-1:0] mul_shift_add(input logic [data_w_lp-1:0] a,
                                                          input logic [data_w_lp-1:0] b);
    logic [2*data_w_lp-1:0] acc;
    acc = '0;
    for (int i = 0; i < data_w_lp; i++) begin
      if (b[i]) acc = acc + ({{data_w_lp{1'b0}}, a} << i);
    end
    return acc;
  endfunction

  // expected writeback from the opcode rules
  function automatic cplx_exec_pkg::wb_pkt_t expect_pkt(input cplx_exec_pkg::issue_pkt_t p);
    cplx_exec_pkg::wb_pkt_t e;
    logic [2*data_w_lp-1:0] prod;
    logic [data_w_lp-1:0]   min_v;
    logic [data_w_lp-1:0]   mag_a;
    logic [data_w_lp-1:0]   mag_b;
    logic [data_w_lp-1:0]   q;
    logic [data_w_lp-1:0]   r;
    logic                   neg_a;
    logic                   neg_b;
    logic                   by_zero;
    min_v   = {1'b1, {(data_w_lp-1){1'b0}}};
    neg_a   = p.src1[data_w_lp-1];
    neg_b   = p.src2[data_w_lp-1];
    by_zero = (p.src2 == '0);
    mag_a   = neg_a ? -p.src1 : p.src1;           // |min| reads as 2^(w-1) unsigned
    mag_b   = neg_b ? -p.src2 : p.src2;
    e       = '0;
    e.tag   = p.tag;
    e.flags.executed  = (p.op != cplx_exec_pkg::syscall);
    e.flags.exception = (p.op == cplx_exec_pkg::syscall);
    case (p.op)
      cplx_exec_pkg::mult_l, cplx_exec_pkg::mult_h: begin
        prod = mul_shift_add(mag_a, mag_b);       // magnitude product
        if (neg_a ^ neg_b) prod = -prod;          // back to two's complement
        e.result = (p.op == cplx_exec_pkg::mult_l) ? prod[data_w_lp-1:0]
                                                   : prod[2*data_w_lp-1:data_w_lp];
      end
      cplx_exec_pkg::multu_l, cplx_exec_pkg::multu_h: begin
        prod = mul_shift_add(p.src1, p.src2);
        e.result = (p.op == cplx_exec_pkg::multu_l) ? prod[data_w_lp-1:0]
                                                    : prod[2*data_w_lp-1:data_w_lp];
      end
      cplx_exec_pkg::div_l, cplx_exec_pkg::div_h: begin
        e.flags.div_zero = by_zero;
        if (by_zero) begin
          q = '1;
          r = p.src1;
        end else if (p.src1 == min_v && p.src2 == '1) begin
          q = min_v;                              // overflow wraps back
          r = '0;
        end else begin
          q = mag_a / mag_b;                      // dividing magnitudes truncates toward zero
          r = mag_a % mag_b;
          if (neg_a ^ neg_b) q = -q;
          if (neg_a) r = -r;                      // sign of the dividend
        end
        e.result = (p.op == cplx_exec_pkg::div_l) ? q : r;
      end
      cplx_exec_pkg::divu_l, cplx_exec_pkg::divu_h: begin
        e.flags.div_zero = by_zero;
        q = by_zero ? '1 : p.src1 / p.src2;
        r = by_zero ? p.src1 : p.src1 % p.src2;
        e.result = (p.op == cplx_exec_pkg::divu_l) ? q : r;
      end
      default: e.result = '0;                     // syscall
    endcase
    return e;
  endfunction

  task automatic check_writeback(input cplx_exec_pkg::wb_pkt_t got);
    cplx_exec_pkg::wb_pkt_t exp_p;
    checked++;
    assert (pending[got.tag]) else begin
      $display("error in %s: writeback for tag %0d, which is not in flight", cur_test, got.tag);
      errors++;
    end
    if (pending[got.tag]) begin
      exp_p = expected[got.tag];
      assert (got == exp_p) else begin
        $display("** Error %s: tag %0d expected result %h flags %b, actual result %h flags %b",
                 cur_test, got.tag, exp_p.result, exp_p.flags, got.result, got.flags);
        errors++;
      end
      pending[got.tag] = 1'b0;                    // each tag retires once
      outstanding--;
    end
  endtask

  // outputs sampled mid cycle
  always @(negedge clk) begin
    if (!reset_i) begin
      if (!issue_ready_o) saw_ready_low = 1'b1;
      if (wb_valid_o) check_writeback(wb_pkt_o);
    end
  end

  task automatic issue_op(input cplx_exec_pkg::alu_op_e op,
                          input logic [data_w_lp-1:0] a, input logic [data_w_lp-1:0] b);
    cplx_exec_pkg::issue_pkt_t p;
    while (pending[next_tag]) @(negedge clk);     // tag still out
    p.tag  = next_tag;
    p.op   = op;
    p.src1 = a;
    p.src2 = b;
    do @(negedge clk); while (!issue_ready_o);    // a free lane stays free while valid is low
    expected[p.tag] = expect_pkt(p);
    pending[p.tag]  = 1'b1;
    outstanding++;
    @(posedge clk);
    issue_valid_i <= 1'b1;
    issue_pkt_i   <= p;
    @(posedge clk);                               // accepted on this edge
    issue_valid_i <= 1'b0;
    next_tag = next_tag + 1'b1;
  endtask

  // base op plus the next three codes
  task automatic issue_group(input cplx_exec_pkg::alu_op_e base,
                             input logic [data_w_lp-1:0] a, input logic [data_w_lp-1:0] b);
    for (int i = 0; i < 4; i++) begin
      issue_op(cplx_exec_pkg::alu_op_e'(4'(int'(base) + i)), a, b);
    end
  endtask

  task automatic wait_drain();
    while (outstanding != 0) @(negedge clk);      // until every issued tag retired
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = errors;
    test_chk0 = checked;
  endtask

  task automatic finish_test();
    int errs;
    errs = errors - test_err0;
    if (errs == 0) tests_pass++;
    else tests_fail++;
    $display("%-12s %0d results checked, %0d errors, %s", cur_test, checked - test_chk0,
             errs, (errs == 0) ? "PASS" : "FAIL");
  endtask

  `include "tb_complex_exec_tests.svh"

  initial begin
    reset_i       = 1'b1;
    issue_valid_i = 1'b0;
    issue_pkt_i   = '0;
    foreach (pending[i]) pending[i] = 1'b0;
    repeat (reset_cycles_lp) @(posedge clk);
    reset_i <= 1'b0;
    reset_state_check();
    multiply_ops();
    divide_ops();
    divide_corners();
    syscall_ops();
    saturation_burst();
    $display("summary: %0d tests pass, %0d tests fail, %0d errors, %0d results checked",
             tests_pass, tests_fail, errors, checked);
    if (errors == 0 && tests_fail == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* writeback_arbiter.sv */
`timescale 1ns/1ps

module writeback_arbiter #(
  parameter int num_lanes_p = 3
) (
  input  logic                                       clk,
  input  logic                                       reset_i,
  input  logic [num_lanes_p-1:0]                     done_i,     // finished lanes
  input  cplx_exec_pkg::wb_pkt_t [num_lanes_p-1:0]   lane_wb_i,  // held while done
  output logic [num_lanes_p-1:0]                     grant_o,    // one cycle pulse
  output logic                                       wb_valid_o, // strobe
  output cplx_exec_pkg::wb_pkt_t                     wb_pkt_o
);

  localparam int ptr_w_lp = (num_lanes_p > 1) ? $clog2(num_lanes_p) : 1;
  localparam logic [ptr_w_lp-1:0] last_lp = ptr_w_lp'(num_lanes_p - 1);

  logic [ptr_w_lp-1:0]    next_r;      // search starts here
  logic [ptr_w_lp-1:0]    sel;         // granted lane index
  logic                   any_grant;
  logic                   wb_valid_r;
  cplx_exec_pkg::wb_pkt_t wb_pkt_r;

  // rotate from next_r, first done lane wins
  always_comb begin : rr_pick
    int idx;
    logic found;
    found   = 1'b0;
    grant_o = '0;
    sel     = '0;
    for (int i = 0; i < num_lanes_p; i++) begin
      idx = int'(next_r) + i;
      if (idx >= num_lanes_p) idx = idx - num_lanes_p;   // wrap
      if (!found && done_i[idx]) begin
        found        = 1'b1;
        grant_o[idx] = 1'b1;
        sel          = ptr_w_lp'(idx);
      end
    end
  end

  assign any_grant = |grant_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      next_r     <= '0;                 // lane 0 first after reset
      wb_valid_r <= 1'b0;
    end else begin
      wb_valid_r <= any_grant;          // one cycle after grant
      if (any_grant) begin
        next_r <= (sel == last_lp) ? '0 : sel + ptr_w_lp'(1);
      end
    end
  end

  // output payload, meaningful only with wb_valid_o
  always_ff @(posedge clk) begin
    if (any_grant) begin
      wb_pkt_r <= lane_wb_i[sel];
    end
  end

  assign wb_valid_o = wb_valid_r;
  assign wb_pkt_o   = wb_pkt_r;

  // single writeback port, one winner
  a_grant_onehot: assert property (@(posedge clk) disable iff (reset_i) $onehot0(grant_o));
  // never grant an idle lane
  a_grant_subset: assert property (@(posedge clk) disable iff (reset_i)
                                   (grant_o & ~done_i) == '0);

endmodule
